//--- hdl/wbxbc_consts.svh
`ifndef WBXBC_CONSTS_SVH
`define WBXBC_CONSTS_SVH

// arbiter size
//--------------------
`define WBXBC_ITR_CNT      4     // initiators sharing the target

// bus widths
//--------------------
`define WBXBC_ADR_WIDTH    16    // address bus
`define WBXBC_DAT_WIDTH    16    // read and write data buses
`define WBXBC_SEL_WIDTH    2     // byte selects, one per data byte

// tag widths
//--------------------
`define WBXBC_TGA_WIDTH    1     // address tags, prio bit not included
`define WBXBC_TGC_WIDTH    1     // cycle tags
`define WBXBC_TGRD_WIDTH   1     // read data tags
`define WBXBC_TGWD_WIDTH   1     // write data tags

`endif

//--- hdl/wbxbc_pkg.sv
`include "wbxbc_consts.svh"

package wbxbc_pkg;

   // initiator bookkeeping
   //--------------------
   typedef logic [$clog2(`WBXBC_ITR_CNT)-1:0] itr_idx_t;  // initiator index
   typedef logic [`WBXBC_ITR_CNT-1:0]         itr_vec_t;  // one bit per initiator

   // arbiter FSM
   typedef enum logic
   {
      ARB_IDLE,                                    // no owner, waiting for cyc
      ARB_BUSY                                     // bus granted to owner
   } arb_state_e;

   // initiator to target
   //--------------------
   typedef struct packed
   {
      logic                          cyc;          // bus cycle indicator
      logic                          stb;          // access request
      logic                          we;           // write enable
      logic                          lock;         // uninterruptable cycle
      logic [`WBXBC_SEL_WIDTH-1:0]   sel;          // byte selects
      logic [`WBXBC_ADR_WIDTH-1:0]   adr;          // address
      logic [`WBXBC_DAT_WIDTH-1:0]   dat;          // write data
      logic [`WBXBC_TGA_WIDTH-1:0]   tga;          // address tags
      logic [`WBXBC_TGC_WIDTH-1:0]   tgc;          // cycle tags
      logic [`WBXBC_TGWD_WIDTH-1:0]  tgd;          // write data tags
   } wb_req_t;

   // request as seen at an initiator port, prio tag on top
   typedef struct packed
   {
      wb_req_t                       req;          // fields that reach the target
      logic                          prio;         // priority address tag
   } wb_itr_req_t;

   // target to initiator
   //--------------------
   typedef struct packed
   {
      logic                          ack;          // normal termination
      logic                          err;          // error termination
      logic                          rty;          // retry termination
      logic                          stall;        // pipeline back-pressure
      logic [`WBXBC_DAT_WIDTH-1:0]   dat;          // read data
      logic [`WBXBC_TGRD_WIDTH-1:0]  tgd;          // read data tags
   } wb_rsp_t;

endpackage

//--- hdl/wbxbc_prio_select.sv
`timescale 1ns/1ps
`include "wbxbc_consts.svh"

module wbxbc_prio_select
(
   // request vectors
   //--------------------
   input  wbxbc_pkg::itr_vec_t  cyc_i,         // cyc of every initiator
   input  wbxbc_pkg::itr_vec_t  prio_i,        // prio tag of every initiator

   // selection
   //--------------------
   output wbxbc_pkg::itr_idx_t  cand_o,        // initiator that would win now
   output logic                 cand_vld_o     // some initiator wants the bus
);

   import wbxbc_pkg::*;

   itr_vec_t  hi_req;                          // requests carrying prio
   itr_vec_t  pick_vec;                        // class that gets looked at

   // scan from the top so the lowest set bit is kept last
   function automatic itr_idx_t lowest_idx(input itr_vec_t vec);
      itr_idx_t idx;
      idx = '0;                                // default if vec is empty
      for (int i = `WBXBC_ITR_CNT-1; i >= 0; i--)
      begin
         if (vec[i])
         begin
            idx = itr_idx_t'(i);               // lower index overwrites
         end
      end
      return idx;
   endfunction

   // class choice
   //--------------------
   assign hi_req   = cyc_i & prio_i;           // high class members
   assign pick_vec = (|hi_req) ? hi_req        // high class first
                               : cyc_i;        // else all requesters

   // candidate
   //--------------------
   assign cand_o     = lowest_idx(pick_vec);   // lowest index in the class
   assign cand_vld_o = |cyc_i;                 // any cyc raised

endmodule

//--- hdl/wbxbc_grant_ctrl.sv
`timescale 1ns/1ps
`include "wbxbc_consts.svh"

module wbxbc_grant_ctrl
(
   // clock and reset
   //--------------------
   input  logic                 clk_i,         // bus clock
   input  logic                 reset_i,       // sync reset, active high

   // candidate from prio select
   //--------------------
   input  wbxbc_pkg::itr_idx_t  cand_i,        // proposed owner
   input  logic                 cand_vld_i,    // proposal is real

   // initiator levels
   //--------------------
   input  wbxbc_pkg::itr_vec_t  cyc_i,         // cyc of every initiator
   input  wbxbc_pkg::itr_vec_t  lock_i,        // lock of every initiator

   // grant
   //--------------------
   output wbxbc_pkg::itr_idx_t  owner_o,       // registered owner index
   output logic                 busy_o         // owner is valid
);

   import wbxbc_pkg::*;

   arb_state_e  state_q;                       // current FSM state
   arb_state_e  state_d;                       // next FSM state
   itr_idx_t    owner_q;                       // current owner
   itr_idx_t    owner_d;                       // next owner
   logic        owner_cyc;                     // owner still in a cycle
   logic        owner_lock;                    // owner holds the bus over gaps

   // owner levels
   //--------------------
   assign owner_cyc  = cyc_i[owner_q];         // pick out owner's cyc
   assign owner_lock = lock_i[owner_q];        // pick out owner's lock

   // next state
   //--------------------
   always_comb
   begin
      state_d = state_q;                       // hold by default
      owner_d = owner_q;
      case (state_q)
         ARB_IDLE:
         begin
            if (cand_vld_i)
            begin
               state_d = ARB_BUSY;             // grant on first request
               owner_d = cand_i;               // winner of prio select
            end
         end
         ARB_BUSY:
         begin
            if (!owner_cyc && !owner_lock)
            begin
               state_d = ARB_IDLE;             // owner let go of the bus
            end
         end
         default:
         begin
            state_d = ARB_IDLE;                // recover from bad encoding
         end
      endcase
   end

   // state registers
   //--------------------
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_q <= ARB_IDLE;                  // nobody owns the bus
         owner_q <= '0;
      end
      else
      begin
         state_q <= state_d;
         owner_q <= owner_d;
      end
   end

   // outputs
   //--------------------
   assign owner_o = owner_q;                   // straight from the register
   assign busy_o  = (state_q == ARB_BUSY);     // grant is active

endmodule

//--- hdl/wbxbc_bus_mux.sv
`timescale 1ns/1ps
`include "wbxbc_consts.svh"

module wbxbc_bus_mux
(
   // initiator side
   //--------------------
   input  wbxbc_pkg::wb_itr_req_t  itr_req_i [`WBXBC_ITR_CNT],  // requests in
   output wbxbc_pkg::wb_rsp_t      itr_rsp_o [`WBXBC_ITR_CNT],  // responses out

   // target side
   //--------------------
   output wbxbc_pkg::wb_req_t      tgt_req_o,  // request to target
   input  wbxbc_pkg::wb_rsp_t      tgt_rsp_i,  // response from target

   // grant
   //--------------------
   input  wbxbc_pkg::itr_idx_t     owner_i,    // current owner
   input  logic                    busy_i      // owner is valid
);

   import wbxbc_pkg::*;

   // request mux
   //--------------------
   always_comb
   begin
      tgt_req_o = itr_req_i[owner_i].req;      // owner's fields, prio dropped
      if (!busy_i)
      begin
         tgt_req_o.cyc = 1'b0;                 // no cycle without a grant
         tgt_req_o.stb = 1'b0;                 // no strobe without a grant
      end
   end

   // response demux
   //--------------------
   always_comb
   begin
      for (int i = 0; i < `WBXBC_ITR_CNT; i++)
      begin
         if (busy_i && (owner_i == itr_idx_t'(i)))
         begin
            itr_rsp_o[i].ack   = tgt_rsp_i.ack;    // owner sees terminations
            itr_rsp_o[i].err   = tgt_rsp_i.err;
            itr_rsp_o[i].rty   = tgt_rsp_i.rty;
            itr_rsp_o[i].stall = tgt_rsp_i.stall;  // target back-pressure
         end
         else
         begin
            itr_rsp_o[i].ack   = 1'b0;             // nothing for a waiter
            itr_rsp_o[i].err   = 1'b0;
            itr_rsp_o[i].rty   = 1'b0;
            itr_rsp_o[i].stall = 1'b1;             // hold off its strobes
         end

         // read data is only looked at together with ack
         itr_rsp_o[i].dat = tgt_rsp_i.dat;         // broadcast read data
         itr_rsp_o[i].tgd = tgt_rsp_i.tgd;         // broadcast read tag
      end
   end

endmodule

//--- hdl/wbxbc_arbiter.sv
`timescale 1ns/1ps
`include "wbxbc_consts.svh"

module wbxbc_arbiter
(
   // clock and reset
   //--------------------
   input  logic                    clk_i,      // bus clock
   input  logic                    reset_i,    // sync reset, active high

   // initiator side
   //--------------------
   input  wbxbc_pkg::wb_itr_req_t  itr_req_i [`WBXBC_ITR_CNT],  // requests in
   output wbxbc_pkg::wb_rsp_t      itr_rsp_o [`WBXBC_ITR_CNT],  // responses out

   // target side
   //--------------------
   output wbxbc_pkg::wb_req_t      tgt_req_o,  // shared target request
   input  wbxbc_pkg::wb_rsp_t      tgt_rsp_i   // shared target response
);

   import wbxbc_pkg::*;

   itr_vec_t  cyc_vec;                         // cyc per initiator
   itr_vec_t  prio_vec;                        // prio tag per initiator
   itr_vec_t  lock_vec;                        // lock per initiator
   itr_idx_t  cand;                            // prio select result
   logic      cand_vld;                        // some cyc is high
   itr_idx_t  owner;                           // registered owner
   logic      busy;                            // grant active

   // level vectors
   //--------------------
   always_comb
   begin
      for (int i = 0; i < `WBXBC_ITR_CNT; i++)
      begin
         cyc_vec[i]  = itr_req_i[i].req.cyc;   // request indicator
         prio_vec[i] = itr_req_i[i].prio;      // priority class
         lock_vec[i] = itr_req_i[i].req.lock;  // keep through cyc gaps
      end
   end

   // arbitration
   //--------------------
   wbxbc_prio_select u_prio_select
   (
      .cyc_i      (cyc_vec),
      .prio_i     (prio_vec),
      .cand_o     (cand),
      .cand_vld_o (cand_vld)
   );

   wbxbc_grant_ctrl u_grant_ctrl
   (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .cand_i     (cand),
      .cand_vld_i (cand_vld),
      .cyc_i      (cyc_vec),
      .lock_i     (lock_vec),
      .owner_o    (owner),
      .busy_o     (busy)
   );

   // bus routing
   //--------------------
   wbxbc_bus_mux u_bus_mux
   (
      .itr_req_i  (itr_req_i),
      .itr_rsp_o  (itr_rsp_o),
      .tgt_req_o  (tgt_req_o),
      .tgt_rsp_i  (tgt_rsp_i),
      .owner_i    (owner),
      .busy_i     (busy)
   );

endmodule

//--- testbench/tb_wb_target.sv
`timescale 1ns/1ps
`include "wbxbc_consts.svh"

module tb_wb_target
(
   input  logic                clk_i,          // bus clock
   input  logic                reset_i,        // sync reset, active high
   input  wbxbc_pkg::wb_req_t  req_i,          // request from the arbiter
   output wbxbc_pkg::wb_rsp_t  rsp_o           // response to the arbiter
);

   import wbxbc_pkg::*;

   // one strobe waiting for its answer
   typedef struct packed
   {
      logic                          vld;      // slot holds a strobe
      logic [`WBXBC_ADR_WIDTH-1:0]   adr;      // strobe address
      logic [`WBXBC_TGWD_WIDTH-1:0]  tgd;      // write tag to echo
   } slot_t;

   slot_t   pipe_q [2];                        // two cycle answer delay
   logic    stall_q;                           // random back-pressure
   integer  stall_seed;                        // private random stream

   initial
   begin
      stall_seed = 32'h3673_52a6;
      stall_q    = 1'b0;
   end

   // stall changes away from the sampling edge
   always @(negedge clk_i)
   begin
      if (reset_i)
         stall_q <= 1'b0;
      else
         stall_q <= (($random(stall_seed) & 3) == 0);  // stall about a quarter
   end

   // strobe delay line
   //--------------------
   always @(posedge clk_i)
   begin
      if (reset_i)
      begin
         pipe_q[0] <= '0;
         pipe_q[1] <= '0;
      end
      else
      begin
         pipe_q[0].vld <= req_i.cyc && req_i.stb && !stall_q;  // transfer seen
         pipe_q[0].adr <= req_i.adr;
         pipe_q[0].tgd <= req_i.tgd;
         pipe_q[1]     <= pipe_q[0];           // second cycle of latency
      end
   end

   // response
   //--------------------
   always_comb
   begin
      rsp_o.stall = stall_q;
      rsp_o.ack   = pipe_q[1].vld && (pipe_q[1].adr[15:12] != 4'hF);
      rsp_o.err   = pipe_q[1].vld && (pipe_q[1].adr[15:12] == 4'hF);  // F page fails
      rsp_o.rty   = 1'b0;                      // never asks for retry
      rsp_o.dat   = pipe_q[1].vld ? (pipe_q[1].adr ^ 16'h5A5A) : '0;
      rsp_o.tgd   = pipe_q[1].tgd;             // echo of the write tag
   end

endmodule

//--- testbench/tb_wbxbc_arbiter.sv
`timescale 1ns/1ps
`include "wbxbc_consts.svh"

module tb_wbxbc_arbiter;

   import wbxbc_pkg::*;

   localparam int TEST_CNT    = 6;
   localparam int STB_MAX     = 8;
   localparam int CYC_PER_STB = 20;
   localparam int CYC_LIMIT   = TEST_CNT * `WBXBC_ITR_CNT * STB_MAX * CYC_PER_STB;

   logic         clk_i;
   logic         reset_i;
   wb_itr_req_t  itr_req [`WBXBC_ITR_CNT];     // initiator requests
   wb_rsp_t      itr_rsp [`WBXBC_ITR_CNT];     // initiator responses
   wb_req_t      tgt_req;                      // shared target request
   wb_rsp_t      tgt_rsp;                      // shared target response

   logic [15:0]  adr_q [`WBXBC_ITR_CNT][$];    // addresses in flight
   int           term_cnt [`WBXBC_ITR_CNT];    // terminations seen
   int           xfer_cnt [`WBXBC_ITR_CNT];    // strobes transferred
   int           pass_cnt;
   int           fail_cnt;
   int           cyc_cnt;
   int           first_xfer;                   // first initiator to transfer
   int           gap_waiter;                   // initiator locked out, -1 off
   integer       seed;
   int           rnd_n [`WBXBC_ITR_CNT];
   logic [15:0]  rnd_base [`WBXBC_ITR_CNT];
   logic         rnd_prio [`WBXBC_ITR_CNT];

   wbxbc_arbiter u_dut
   (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .itr_req_i (itr_req),
      .itr_rsp_o (itr_rsp),
      .tgt_req_o (tgt_req),
      .tgt_rsp_i (tgt_rsp)
   );

   tb_wb_target u_target
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (tgt_req),
      .rsp_o   (tgt_rsp)
   );

   initial
   begin
      clk_i = 1'b0;
   end

   always #5 clk_i = ~clk_i;                   // 10 ns period

   // reference model
   //--------------------
   function automatic logic [15:0] ref_rdat(input logic [15:0] adr);
      return adr ^ 16'h5A5A;                   // target read pattern
   endfunction

   // lowest prio requester, else lowest requester
   function automatic int winner_of(input logic [3:0] cyc, input logic [3:0] prio);
      for (int i = 0; i < `WBXBC_ITR_CNT; i++)
         if (cyc[i] && prio[i])
            return i;
      for (int i = 0; i < `WBXBC_ITR_CNT; i++)
         if (cyc[i])
            return i;
      return -1;
   endfunction

   task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp) pass_cnt++;
      else
      begin
         fail_cnt++;
         $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond) pass_cnt++;
      else
      begin
         fail_cnt++;
         $display("Error at %0t: %s", $time, what);
      end
   endtask

   // compare
   //--------------------
   task automatic check_term(input int i);
      logic [15:0] a;
      if (adr_q[i].size() == 0)
      begin
         check_true(1'b0, "termination reached an initiator with no strobe in flight");
      end
      else
      begin
         a = adr_q[i].pop_front();             // oldest strobe answers first
         term_cnt[i]++;
         check_eq("itr_rsp_o.rty", itr_rsp[i].rty, 0);
         check_eq("itr_rsp_o.err", itr_rsp[i].err, a[15:12] == 4'hF);
         check_eq("itr_rsp_o.ack", itr_rsp[i].ack, a[15:12] != 4'hF);
         if (itr_rsp[i].ack)
            check_eq("itr_rsp_o.dat", itr_rsp[i].dat, ref_rdat(a));
         check_eq("itr_rsp_o.tgd", itr_rsp[i].tgd, a[0]);
      end
   endtask

   task automatic compare_cycle();
      int   hits;
      int   who;
      logic any_cyc;
      logic tgt_xfer;
      hits    = 0;
      who     = -1;
      any_cyc = 1'b0;
      for (int i = 0; i < `WBXBC_ITR_CNT; i++)
      begin
         any_cyc |= itr_req[i].req.cyc;
         if (itr_rsp[i].ack || itr_rsp[i].err || itr_rsp[i].rty)
            check_term(i);                     // pop before push
         if (itr_req[i].req.cyc && itr_req[i].req.stb && !itr_rsp[i].stall)
         begin
            hits++;
            who = i;
            adr_q[i].push_back(itr_req[i].req.adr);
            xfer_cnt[i]++;
         end
      end
      if (!any_cyc)
         check_true(!tgt_req.cyc && !tgt_req.stb, "target saw cyc or stb with no initiator active");
      tgt_xfer = tgt_req.cyc && tgt_req.stb && !tgt_rsp.stall;
      check_true(hits == (tgt_xfer ? 1 : 0), "initiator and target transfers do not match");
      if (tgt_xfer && (who >= 0))
         check_eq("tgt_req_o", tgt_req, itr_req[who].req);  // fields pass unchanged
      if ((who >= 0) && (first_xfer < 0))
         first_xfer = who;
      if (gap_waiter >= 0)
         check_true(tgt_req.adr != itr_req[gap_waiter].req.adr,
                    "waiting initiator's address reached the target while locked out");
   endtask

   // sample just before the rising edge
   always
   begin
      @(negedge clk_i);
      #4;
      if (!reset_i)
         compare_cycle();
   end

   // run limit
   always @(posedge clk_i)
   begin
      cyc_cnt++;
      if (cyc_cnt >= CYC_LIMIT)
      begin
         $display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
         $display("TB FAILED");
         $finish;
      end
   end

   // initiator
   //--------------------
   task automatic burst(input int idx, input int n, input logic [15:0] base,
                        input logic keep_lock, input logic prio);
      int          sent;
      int          term_base;
      wb_itr_req_t r;
      sent      = 0;
      term_base = term_cnt[idx];
      forever
      begin
         @(negedge clk_i);
         r = '0;
         if (term_cnt[idx] - term_base >= n)
         begin
            r.req.adr  = itr_req[idx].req.adr; // keep last address
            r.req.lock = keep_lock;            // lock may bridge a gap
            itr_req[idx] = r;
            break;
         end
         r.req.cyc  = 1'b1;
         r.req.stb  = (sent < n);
         r.req.we   = sent[0];
         r.req.lock = keep_lock;
         r.req.adr  = base + 16'(sent);
         r.req.sel  = r.req.adr[2:1];          // changes from strobe to strobe
         r.req.dat  = ~r.req.adr;
         r.req.tga  = ~r.req.adr[0];
         r.req.tgc  = r.req.adr[1];
         r.req.tgd  = r.req.adr[0];            // echoed back as read tag
         r.prio     = prio;
         itr_req[idx] = r;
         #4;
         if (itr_req[idx].req.stb && !itr_rsp[idx].stall)
            sent++;                            // strobe accepted
      end
   endtask

   task automatic end_test(input int num, input string name);
      int errs;
      errs = fail_cnt;
      repeat (4) @(negedge clk_i);             // let stray terminations show
      for (int i = 0; i < `WBXBC_ITR_CNT; i++)
      begin
         check_eq("itr_rsp_o termination count", term_cnt[i], xfer_cnt[i]);
         check_eq("strobes in flight", adr_q[i].size(), 0);
      end
      $display("test %0d %s finished, %0d new errors", num, name, fail_cnt - errs);
   endtask

   // stimulus
   //--------------------
   initial
   begin
      seed       = 32'h3673_52a6;
      reset_i    = 1'b1;
      pass_cnt   = 0;
      fail_cnt   = 0;
      cyc_cnt    = 0;
      first_xfer = -1;
      gap_waiter = -1;
      for (int i = 0; i < `WBXBC_ITR_CNT; i++)
      begin
         itr_req[i]  = '0;
         term_cnt[i] = 0;
         xfer_cnt[i] = 0;
      end
      repeat (8) @(negedge clk_i);
      reset_i = 1'b0;

      repeat (10) @(negedge clk_i);            // idle bus stays quiet
      end_test(1, "idle after reset");

      burst(0, 6, 16'hEFFC, 1'b0, 1'b0);       // crosses into the F page
      end_test(2, "single initiator");

      first_xfer = -1;
      fork
         burst(0, 4, 16'h1000, 1'b0, 1'b0);
         burst(1, 4, 16'h1100, 1'b0, 1'b1);
         burst(3, 4, 16'h1300, 1'b0, 1'b1);
      join
      check_eq("first owner", first_xfer, winner_of(4'b1011, 4'b1010));
      end_test(3, "priority contention");

      first_xfer = -1;
      fork
         burst(2, 8, 16'h4200, 1'b0, 1'b0);
         burst(3, 8, 16'hF300, 1'b0, 1'b0);
      join
      check_eq("first owner", first_xfer, winner_of(4'b1100, 4'b0000));
      end_test(4, "pipelined burst");

      fork
         begin
            burst(0, 4, 16'h2000, 1'b1, 1'b0); // ends with lock still high
            gap_waiter = 1;
            burst(0, 4, 16'h2100, 1'b0, 1'b0);
            gap_waiter = -1;
         end
         begin
            repeat (2) @(negedge clk_i);
            burst(1, 4, 16'h3000, 1'b0, 1'b1); // prio waiter wins any idle edge
         end
      join
      end_test(5, "lock through cyc gap");

      for (int i = 0; i < `WBXBC_ITR_CNT; i++)
      begin
         rnd_n[i]    = 1 + ($random(seed) & 7);
         rnd_prio[i] = $random(seed) & 1;
         rnd_base[i] = {(($random(seed) & 1) ? 4'hF : 4'(i + 4)), 8'(i), 4'h0};
      end
      fork
         burst(0, rnd_n[0], rnd_base[0], 1'b0, rnd_prio[0]);
         burst(1, rnd_n[1], rnd_base[1], 1'b0, rnd_prio[1]);
         burst(2, rnd_n[2], rnd_base[2], 1'b0, rnd_prio[2]);
         burst(3, rnd_n[3], rnd_base[3], 1'b0, rnd_prio[3]);
      join
      end_test(6, "random contention");

      $display("checks passed %0d, checks failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

//--- tb.f
+incdir+hdl
hdl/wbxbc_pkg.sv
hdl/wbxbc_prio_select.sv
hdl/wbxbc_grant_ctrl.sv
hdl/wbxbc_bus_mux.sv
hdl/wbxbc_arbiter.sv
testbench/tb_wb_target.sv
testbench/tb_wbxbc_arbiter.sv

//--- Makefile
# Verilator flow for the Wishbone arbiter testbench

SIM      = verilator
TOP      = tb_wbxbc_arbiter
FILELIST = tb.f
OBJDIR   = obj_dir
FLAGS    = --timing --assert -Wno-fatal --top-module $(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) -f $(FILELIST)

build:
	$(SIM) --binary $(FLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
sim: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJDIR)
